//--- sim.f
design/zhx_pkg.sv
design/zhx_regfile.sv
design/zhx_fetch.sv
design/zhx_decode.sv
design/zhx_alu.sv
design/zhx_mem_unit.sv
design/zhx_writeback.sv
design/zhxpu.sv
testbench/tb_clock.sv
testbench/zhxpu_properties.sv
testbench/tb_zhxpu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the zhxpu testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f sim.f --top-module tb_zhxpu -o tb_zhxpu > build.log 2>&1 \
	&& ./obj_dir/tb_zhxpu > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || grep -q "Simulation passed" sim.log || exit 1

//--- testbench/tb_zhxpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zhxpu;

	localparam int mem_wait = 2;
	localparam int dmem_depth = 256;
	localparam int pad_len = 16;

	logic clk;
	logic rst_n;
	logic run;
	logic prog_we;
	logic [15:0] prog_addr;
	logic [15:0] prog_data;
	logic [2:0] dbg_addr;
	logic [15:0] dbg_value;
	logic wb_we;
	logic [2:0] wb_addr;
	logic [15:0] wb_value;

	logic [15:0] prog [64];
	int prog_len;
	logic [15:0] m_regs [8];
	logic [15:0] m_mem [dmem_depth];
	logic [2:0] exp_addr [$];
	logic [15:0] exp_value [$];
	int wb_errors = 0;
	int dbg_errors = 0;
	int run_cycles = 0;
	int timeout_cycles;

	tb_clock i_clock (
		.clk(clk),
		.rst_n(rst_n)
	);

	zhxpu #(
		.imem_depth(256),
		.dmem_depth(dmem_depth),
		.mem_wait(mem_wait)
	) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.dbg_addr(dbg_addr),
		.dbg_value(dbg_value),
		.wb_we(wb_we),
		.wb_addr(wb_addr),
		.wb_value(wb_value)
	);

	// li, addiu and beqz share one layout
	function automatic logic [15:0] ri_word(input logic [4:0] op, input logic [2:0] rx,
		input logic [7:0] imm);
		return {op, rx, imm};
	endfunction

	function automatic logic [15:0] rr_word(input logic [2:0] rx, input logic [2:0] ry,
		input logic [2:0] rz, input logic [1:0] fn);
		return {zhx_pkg::op_rr, rx, ry, rz, fn};
	endfunction

	function automatic logic [15:0] logic_word(input logic [2:0] rx, input logic [2:0] ry,
		input logic [4:0] fn);
		return {zhx_pkg::op_logic, rx, ry, fn};
	endfunction

	function automatic logic [15:0] mem_word(input logic [4:0] op, input logic [2:0] rx,
		input logic [2:0] ry, input logic [4:0] imm);
		return {op, rx, ry, imm};
	endfunction

	task automatic append_word(input logic [15:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	task automatic add_random_alu(input int count);
		int kind;
		logic [2:0] rx;
		logic [2:0] ry;
		logic [2:0] rz;
		for (int i = 0; i < count; i++) begin
			kind = int'($urandom % 6);
			rx = 3'($urandom);
			ry = 3'($urandom);
			rz = 3'($urandom);
			case (kind)
				0: append_word(ri_word(zhx_pkg::op_li, rx, 8'($urandom)));
				1: append_word(ri_word(zhx_pkg::op_addiu, rx, 8'($urandom)));
				2: append_word(rr_word(rx, ry, rz, zhx_pkg::fn_addu));
				3: append_word(rr_word(rx, ry, rz, zhx_pkg::fn_subu));
				4: append_word(logic_word(rx, ry, zhx_pkg::fn_and));
				default: append_word(logic_word(rx, ry, zhx_pkg::fn_or));
			endcase
		end
	endtask

	task automatic build_program();
		logic [7:0] base;
		logic [4:0] off_a;
		logic [4:0] off_b;
		prog_len = 0;
		for (int r = 0; r < 8; r++) begin
			append_word(ri_word(zhx_pkg::op_li, 3'(r), 8'($urandom)));
		end
		// each result feeds the next instruction
		append_word(rr_word(3'd1, 3'd2, 3'd3, zhx_pkg::fn_addu));
		append_word(ri_word(zhx_pkg::op_addiu, 3'd3, 8'($urandom)));
		append_word(rr_word(3'd3, 3'd1, 3'd4, zhx_pkg::fn_subu));
		append_word(logic_word(3'd4, 3'd3, zhx_pkg::fn_and));
		append_word(logic_word(3'd4, 3'd5, zhx_pkg::fn_or));
		append_word(rr_word(3'd4, 3'd4, 3'd0, zhx_pkg::fn_addu));
		add_random_alu(8);
		// r6 is the base, two distinct offsets
		base = 8'($urandom);
		off_a = 5'($urandom);
		off_b = off_a ^ 5'(1 + $urandom % 31);
		append_word(ri_word(zhx_pkg::op_li, 3'd6, base));
		append_word(mem_word(zhx_pkg::op_sw, 3'd6, 3'd1, off_a));
		append_word(mem_word(zhx_pkg::op_sw, 3'd6, 3'd2, off_b));
		append_word(mem_word(zhx_pkg::op_lw, 3'd6, 3'd5, off_a));
		append_word(mem_word(zhx_pkg::op_lw, 3'd6, 3'd7, off_b));
		// load-use on r7
		append_word(rr_word(3'd5, 3'd7, 3'd4, zhx_pkg::fn_addu));
		append_word(mem_word(zhx_pkg::op_sw, 3'd6, 3'd4, off_a));
		append_word(mem_word(zhx_pkg::op_lw, 3'd6, 3'd3, off_a));
		// taken beqz, delay slot runs, two skipped
		append_word(ri_word(zhx_pkg::op_li, 3'd2, 8'h00));
		append_word(ri_word(zhx_pkg::op_beqz, 3'd2, 8'd3));
		append_word(ri_word(zhx_pkg::op_li, 3'd3, 8'($urandom)));
		append_word(ri_word(zhx_pkg::op_li, 3'd4, 8'($urandom)));
		append_word(ri_word(zhx_pkg::op_li, 3'd5, 8'($urandom)));
		// not taken, r1 is nonzero
		append_word(ri_word(zhx_pkg::op_li, 3'd1, 8'(1 + $urandom % 255)));
		append_word(ri_word(zhx_pkg::op_beqz, 3'd1, 8'd2));
		append_word(ri_word(zhx_pkg::op_addiu, 3'd1, 8'($urandom)));
		append_word(rr_word(3'd1, 3'd3, 3'd7, zhx_pkg::fn_addu));
		add_random_alu(6);
	endtask

	task automatic set_model_reg(input logic [2:0] addr, input logic [15:0] value);
		m_regs[addr] = value;
		exp_addr.push_back(addr);
		exp_value.push_back(value);
	endtask

	// instruction-level model with one delay slot
	task automatic run_model();
		logic [15:0] ins;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] ea;
		int pc;
		int steps;
		int jump_addr;
		int jump_to;
		bit jump_pending;
		bit jump_now;
		pc = 0;
		steps = 0;
		jump_addr = 0;
		jump_pending = 1'b0;
		for (int i = 0; i < 8; i++) begin
			m_regs[i] = 16'h0;
		end
		while (pc < prog_len && steps < 1000) begin
			ins = prog[pc];
			jump_now = jump_pending;
			jump_to = jump_addr;
			jump_pending = 1'b0;
			a = m_regs[ins[10:8]];
			b = m_regs[ins[7:5]];
			ea = a + {{11{ins[4]}}, ins[4:0]};
			case (ins[15:11])
				zhx_pkg::op_li: set_model_reg(ins[10:8], {8'h00, ins[7:0]});
				zhx_pkg::op_addiu: set_model_reg(ins[10:8], a + {{8{ins[7]}}, ins[7:0]});
				zhx_pkg::op_rr: set_model_reg(ins[4:2],
					(ins[1:0] == zhx_pkg::fn_subu) ? a - b : a + b);
				zhx_pkg::op_logic: set_model_reg(ins[10:8],
					(ins[4:0] == zhx_pkg::fn_or) ? a | b : a & b);
				zhx_pkg::op_lw: set_model_reg(ins[7:5], m_mem[int'(ea) % dmem_depth]);
				zhx_pkg::op_sw: m_mem[int'(ea) % dmem_depth] = b;
				zhx_pkg::op_beqz: begin
					if (a == 16'h0) begin
						jump_pending = 1'b1;
						jump_addr = pc + 1 + int'($signed(ins[7:0]));
					end
				end
				default: begin
				end
			endcase
			pc = jump_now ? jump_to : pc + 1;
			steps++;
		end
	endtask

	// program plus a tail of nops for the fetches past the end
	task automatic load_program();
		for (int i = 0; i < prog_len + pad_len; i++) begin
			@(posedge clk);
			prog_we <= 1'b1;
			prog_addr <= 16'(i);
			prog_data <= (i < prog_len) ? prog[i] : {zhx_pkg::op_nop, 11'b0};
		end
		@(posedge clk);
		prog_we <= 1'b0;
	endtask

	task automatic sweep_registers(input bit after_run);
		logic [15:0] expected;
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			dbg_addr <= 3'(i);
			@(negedge clk);
			expected = after_run ? m_regs[i] : 16'h0;
			assert (dbg_value == expected) else begin
				dbg_errors++;
				$display("** Error at %0t: debug read r%0d = %h, expected %h", $time, i,
					dbg_value, expected);
			end
		end
	endtask

	// each strobe must match the oldest expected writeback
	always @(negedge clk) begin
		if (rst_n && wb_we) begin
			assert (exp_addr.size() != 0) else begin
				wb_errors++;
				$display("** Error at %0t: writeback r%0d = %h with none expected", $time,
					wb_addr, wb_value);
			end
			if (exp_addr.size() != 0) begin
				assert (wb_addr == exp_addr[0] && wb_value == exp_value[0]) else begin
					wb_errors++;
					$display("** Error at %0t: writeback r%0d = %h, expected r%0d = %h", $time,
						wb_addr, wb_value, exp_addr[0], exp_value[0]);
				end
				void'(exp_addr.pop_front());
				void'(exp_value.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		if (run) begin
			run_cycles <= run_cycles + 1;
			if (run_cycles >= timeout_cycles) begin
				$display("Timeout: the core did not finish the program in %0d cycles",
					timeout_cycles);
				$display("writeback errors: %0d, register errors: %0d", wb_errors,
					dbg_errors);
				$display("Simulation failed");
				$finish;
			end
		end
	end

	initial begin
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = 16'h0;
		prog_data = 16'h0;
		dbg_addr = 3'd0;
		void'($urandom(32'h8bb40f51));
		build_program();
		run_model();
		timeout_cycles = prog_len * (mem_wait + 3) + 50;
		@(posedge clk);
		while (!rst_n) begin
			@(posedge clk);
		end
		sweep_registers(1'b0);
		load_program();
		@(posedge clk);
		run <= 1'b1;
		while (exp_addr.size() != 0) begin
			@(posedge clk);
		end
		// let the tail drain so a stray writeback is still caught
		repeat (mem_wait + 8) @(posedge clk);
		run <= 1'b0;
		repeat (4) @(posedge clk);
		sweep_registers(1'b1);
		$display("writeback errors: %0d, register errors: %0d", wb_errors, dbg_errors);
		if (wb_errors == 0 && dbg_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/zhxpu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module zhxpu_properties #(
	parameter int mem_wait = 2
) (
	input wire clk,
	input wire rst_n,
	input wire run,
	input wire hold,
	input wire wb_we,
	input wire [zhx_pkg::reg_addr_w-1:0] wb_addr,
	input wire [zhx_pkg::xlen-1:0] wb_value
);

	// length of the current run of hold cycles
	int hold_run;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hold_run <= 0;
		end else if (hold) begin
			hold_run <= hold_run + 1;
		end else begin
			hold_run <= 0;
		end
	end

	assert property (@(posedge clk) !rst_n |=> !wb_we && !hold)
		else $error("writeback or hold active right after reset");

	// idle core retires nothing
	assert property (@(posedge clk) disable iff (!rst_n) !run |=> !wb_we)
		else $error("writeback strobe while run is low");

	assert property (@(posedge clk) disable iff (!rst_n) hold_run <= mem_wait)
		else $error("hold stayed high longer than the memory wait");

	assert property (@(posedge clk) disable iff (!rst_n) wb_we |-> !$isunknown({wb_addr, wb_value}))
		else $error("writeback with unknown address or value");

endmodule

bind zhxpu zhxpu_properties #(
	.mem_wait(mem_wait)
) i_properties (
	.clk(clk),
	.rst_n(rst_n),
	.run(run),
	.hold(hold),
	.wb_we(wb_we),
	.wb_addr(wb_addr),
	.wb_value(wb_value)
);

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_n
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held for four rising edges
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- design/zhxpu.sv
`timescale 1ns/1ps
`default_nettype none

module zhxpu #(
	parameter int imem_depth = 256,
	parameter int dmem_depth = 256,
	parameter int mem_wait = 2
) (
	input wire clk,
	input wire rst_n,
	input wire run,
	input wire prog_we,
	input wire [zhx_pkg::xlen-1:0] prog_addr,
	input wire [zhx_pkg::xlen-1:0] prog_data,
	input wire [zhx_pkg::reg_addr_w-1:0] dbg_addr,
	output logic [zhx_pkg::xlen-1:0] dbg_value,
	output logic wb_we,
	output logic [zhx_pkg::reg_addr_w-1:0] wb_addr,
	output logic [zhx_pkg::xlen-1:0] wb_value
);

	// stall and branch control
	logic hold;
	logic stall_id;
	logic set_pc;
	logic [zhx_pkg::xlen-1:0] set_pc_addr;

	// IF
	logic [zhx_pkg::xlen-1:0] if_pc;
	logic [zhx_pkg::xlen-1:0] if_inst;

	// register reads from ID
	logic [zhx_pkg::reg_addr_w-1:0] read_addr1;
	logic [zhx_pkg::reg_addr_w-1:0] read_addr2;
	logic [zhx_pkg::xlen-1:0] read_value1;
	logic [zhx_pkg::xlen-1:0] read_value2;

	// EXE
	logic [2:0] exe_alu_op;
	logic [zhx_pkg::xlen-1:0] exe_op1;
	logic [zhx_pkg::xlen-1:0] exe_op2;
	logic [zhx_pkg::xlen-1:0] exe_store_value;
	logic exe_mem_read;
	logic exe_mem_write;
	logic exe_reg_write;
	logic [zhx_pkg::reg_addr_w-1:0] exe_reg_addr;
	logic [zhx_pkg::xlen-1:0] alu_res;
	logic [zhx_pkg::xlen-1:0] mem_res;

	zhx_fetch #(
		.imem_depth(imem_depth)
	) i_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.hold(hold),
		.stall_id(stall_id),
		.set_pc(set_pc),
		.set_pc_addr(set_pc_addr),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.pc(if_pc),
		.inst(if_inst)
	);

	zhx_decode i_decode (
		.clk(clk),
		.rst_n(rst_n),
		.hold(hold),
		.pc(if_pc),
		.inst(if_inst),
		.read_addr1(read_addr1),
		.read_addr2(read_addr2),
		.read_value1(read_value1),
		.read_value2(read_value2),
		.set_pc(set_pc),
		.set_pc_addr(set_pc_addr),
		.stall_id(stall_id),
		.exe_alu_op(exe_alu_op),
		.exe_op1(exe_op1),
		.exe_op2(exe_op2),
		.exe_store_value(exe_store_value),
		.exe_mem_read(exe_mem_read),
		.exe_mem_write(exe_mem_write),
		.exe_reg_write(exe_reg_write),
		.exe_reg_addr(exe_reg_addr)
	);

	zhx_regfile i_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.read_addr1(read_addr1),
		.read_addr2(read_addr2),
		.read_value1(read_value1),
		.read_value2(read_value2),
		.we(wb_we),
		.write_addr(wb_addr),
		.write_value(wb_value),
		.dbg_addr(dbg_addr),
		.dbg_value(dbg_value)
	);

	// alu and memory run side by side in EXE
	zhx_alu i_alu (
		.alu_op(exe_alu_op),
		.op1(exe_op1),
		.op2(exe_op2),
		.res(alu_res)
	);

	zhx_mem_unit #(
		.dmem_depth(dmem_depth),
		.mem_wait(mem_wait)
	) i_mem_unit (
		.clk(clk),
		.rst_n(rst_n),
		.mem_read(exe_mem_read),
		.mem_write(exe_mem_write),
		.addr(alu_res),
		.store_value(exe_store_value),
		.hold(hold),
		.mem_res(mem_res)
	);

	zhx_writeback i_writeback (
		.clk(clk),
		.rst_n(rst_n),
		.hold(hold),
		.reg_write(exe_reg_write),
		.reg_addr(exe_reg_addr),
		.mem_read(exe_mem_read),
		.alu_res(alu_res),
		.mem_res(mem_res),
		.wb_we(wb_we),
		.wb_addr(wb_addr),
		.wb_value(wb_value)
	);

endmodule

`default_nettype wire

//--- design/zhx_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module zhx_writeback (
	input wire clk,
	input wire rst_n,
	input wire hold,
	input wire reg_write,
	input wire [zhx_pkg::reg_addr_w-1:0] reg_addr,
	input wire mem_read,
	input wire [zhx_pkg::xlen-1:0] alu_res,
	input wire [zhx_pkg::xlen-1:0] mem_res,
	output logic wb_we,
	output logic [zhx_pkg::reg_addr_w-1:0] wb_addr,
	output logic [zhx_pkg::xlen-1:0] wb_value
);

	logic [zhx_pkg::xlen-1:0] res_sel;

	assign res_sel = mem_read ? mem_res : alu_res;

	// one pulse per instruction, none while EXE is held
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_we <= 1'b0;
		end else begin
			wb_we <= reg_write && !hold;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			wb_addr <= reg_addr;
			wb_value <= res_sel;
		end
	end

endmodule

`default_nettype wire

//--- design/zhx_mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module zhx_mem_unit #(
	parameter int dmem_depth = 256,
	parameter int mem_wait = 2
) (
	input wire clk,
	input wire rst_n,
	input wire mem_read,
	input wire mem_write,
	input wire [zhx_pkg::xlen-1:0] addr,
	input wire [zhx_pkg::xlen-1:0] store_value,
	output logic hold,
	output logic [zhx_pkg::xlen-1:0] mem_res
);

	localparam int daw = $clog2(dmem_depth);
	localparam int cw = (mem_wait > 0) ? $clog2(mem_wait + 1) : 1;

	logic [zhx_pkg::xlen-1:0] dmem [dmem_depth];
	logic [cw-1:0] wait_cnt;
	logic [daw-1:0] idx;

	assign idx = addr[daw-1:0];

	// stall until mem_wait cycles have passed for this access
	assign hold = (mem_read || mem_write) && wait_cnt != cw'(mem_wait);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wait_cnt <= '0;
		end else if (hold) begin
			wait_cnt <= wait_cnt + cw'(1);
		end else begin
			// pipeline moves on, next access starts from zero
			wait_cnt <= '0;
		end
	end

	// store lands on the edge that releases the pipeline
	always_ff @(posedge clk) begin
		if (mem_write && !hold) begin
			dmem[idx] <= store_value;
		end
	end

	// picked up by writeback on the release edge
	assign mem_res = dmem[idx];

endmodule

`default_nettype wire

//--- design/zhx_alu.sv
`timescale 1ns/1ps
`default_nettype none

module zhx_alu (
	input wire [2:0] alu_op,
	input wire [zhx_pkg::xlen-1:0] op1,
	input wire [zhx_pkg::xlen-1:0] op2,
	output logic [zhx_pkg::xlen-1:0] res
);

	// also forms the lw and sw address
	always_comb begin
		case (alu_op)
			zhx_pkg::alu_add: begin
				res = op1 + op2;
			end
			zhx_pkg::alu_sub: begin
				res = op1 - op2;
			end
			zhx_pkg::alu_and: begin
				res = op1 & op2;
			end
			zhx_pkg::alu_or: begin
				res = op1 | op2;
			end
			// li
			zhx_pkg::alu_pass_b: begin
				res = op2;
			end
			default: begin
				res = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/zhx_decode.sv
`timescale 1ns/1ps
`default_nettype none

module zhx_decode (
	input wire clk,
	input wire rst_n,
	input wire hold,
	input wire [zhx_pkg::xlen-1:0] pc,
	input wire [zhx_pkg::xlen-1:0] inst,
	output logic [zhx_pkg::reg_addr_w-1:0] read_addr1,
	output logic [zhx_pkg::reg_addr_w-1:0] read_addr2,
	input wire [zhx_pkg::xlen-1:0] read_value1,
	input wire [zhx_pkg::xlen-1:0] read_value2,
	output logic set_pc,
	output logic [zhx_pkg::xlen-1:0] set_pc_addr,
	output logic stall_id,
	output logic [2:0] exe_alu_op,
	output logic [zhx_pkg::xlen-1:0] exe_op1,
	output logic [zhx_pkg::xlen-1:0] exe_op2,
	output logic [zhx_pkg::xlen-1:0] exe_store_value,
	output logic exe_mem_read,
	output logic exe_mem_write,
	output logic exe_reg_write,
	output logic [zhx_pkg::reg_addr_w-1:0] exe_reg_addr
);

	localparam int xl = zhx_pkg::xlen;

	logic [xl-1:0] id_inst;
	logic [xl-1:0] id_pc;
	logic [4:0] opcode;
	logic [zhx_pkg::reg_addr_w-1:0] rx;
	logic [zhx_pkg::reg_addr_w-1:0] ry;
	logic [zhx_pkg::reg_addr_w-1:0] rz;
	logic [xl-1:0] imm8_s;
	logic [xl-1:0] imm8_z;
	logic [xl-1:0] imm5_s;
	logic [2:0] dec_alu_op;
	logic [xl-1:0] dec_op2;
	logic dec_mem_read;
	logic dec_mem_write;
	logic dec_reg_write;
	logic [zhx_pkg::reg_addr_w-1:0] dec_reg_addr;
	logic use1;
	logic use2;

	// IF/ID, frozen by hold and by the interlock
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_inst <= {zhx_pkg::op_nop, 11'b0};
			id_pc <= '0;
		end else if (!hold && !stall_id) begin
			id_inst <= inst;
			id_pc <= pc;
		end
	end

	assign opcode = id_inst[15:11];
	assign rx = id_inst[10:8];
	assign ry = id_inst[7:5];
	assign rz = id_inst[4:2];
	assign imm8_s = {{(xl-8){id_inst[7]}}, id_inst[7:0]};
	assign imm8_z = {{(xl-8){1'b0}}, id_inst[7:0]};
	assign imm5_s = {{(xl-5){id_inst[4]}}, id_inst[4:0]};

	assign read_addr1 = rx;
	assign read_addr2 = ry;

	always_comb begin
		dec_alu_op = zhx_pkg::alu_add;
		dec_op2 = read_value2;
		dec_mem_read = 1'b0;
		dec_mem_write = 1'b0;
		dec_reg_write = 1'b0;
		dec_reg_addr = rx;
		use1 = 1'b0;
		use2 = 1'b0;
		case (opcode)
			zhx_pkg::op_li: begin
				dec_alu_op = zhx_pkg::alu_pass_b;
				dec_op2 = imm8_z;
				dec_reg_write = 1'b1;
			end
			zhx_pkg::op_addiu: begin
				dec_op2 = imm8_s;
				dec_reg_write = 1'b1;
				use1 = 1'b1;
			end
			zhx_pkg::op_rr: begin
				use1 = 1'b1;
				use2 = 1'b1;
				dec_reg_addr = rz;
				dec_reg_write = id_inst[1:0] == zhx_pkg::fn_addu ||
					id_inst[1:0] == zhx_pkg::fn_subu;
				if (id_inst[1:0] == zhx_pkg::fn_subu) begin
					dec_alu_op = zhx_pkg::alu_sub;
				end
			end
			zhx_pkg::op_logic: begin
				use1 = 1'b1;
				use2 = 1'b1;
				dec_reg_write = id_inst[4:0] == zhx_pkg::fn_and ||
					id_inst[4:0] == zhx_pkg::fn_or;
				dec_alu_op = (id_inst[4:0] == zhx_pkg::fn_or) ? zhx_pkg::alu_or :
					zhx_pkg::alu_and;
			end
			zhx_pkg::op_lw: begin
				// ry <- mem[rx + imm5]
				dec_op2 = imm5_s;
				dec_mem_read = 1'b1;
				dec_reg_write = 1'b1;
				dec_reg_addr = ry;
				use1 = 1'b1;
			end
			zhx_pkg::op_sw: begin
				dec_op2 = imm5_s;
				dec_mem_write = 1'b1;
				use1 = 1'b1;
				use2 = 1'b1;
			end
			zhx_pkg::op_beqz: begin
				use1 = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// result of the writer in EXE is not visible yet, wait one cycle
	assign stall_id = exe_reg_write && ((use1 && rx == exe_reg_addr) ||
		(use2 && ry == exe_reg_addr));

	// target is relative to the delay slot
	assign set_pc = opcode == zhx_pkg::op_beqz && read_value1 == '0 && !stall_id;
	assign set_pc_addr = id_pc + xl'(1) + imm8_s;

	// ID/EXE controls, a stall leaves a bubble behind
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exe_alu_op <= zhx_pkg::alu_add;
			exe_mem_read <= 1'b0;
			exe_mem_write <= 1'b0;
			exe_reg_write <= 1'b0;
		end else if (!hold) begin
			exe_alu_op <= stall_id ? zhx_pkg::alu_add : dec_alu_op;
			exe_mem_read <= dec_mem_read && !stall_id;
			exe_mem_write <= dec_mem_write && !stall_id;
			exe_reg_write <= dec_reg_write && !stall_id;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold && !stall_id) begin
			exe_op1 <= read_value1;
			exe_op2 <= dec_op2;
			exe_store_value <= read_value2;
			exe_reg_addr <= dec_reg_addr;
		end
	end

endmodule

`default_nettype wire

//--- design/zhx_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module zhx_fetch #(
	parameter int imem_depth = 256
) (
	input wire clk,
	input wire rst_n,
	input wire run,
	input wire hold,
	input wire stall_id,
	input wire set_pc,
	input wire [zhx_pkg::xlen-1:0] set_pc_addr,
	input wire prog_we,
	input wire [zhx_pkg::xlen-1:0] prog_addr,
	input wire [zhx_pkg::xlen-1:0] prog_data,
	output logic [zhx_pkg::xlen-1:0] pc,
	output logic [zhx_pkg::xlen-1:0] inst
);

	localparam int iaw = $clog2(imem_depth);

	logic [zhx_pkg::xlen-1:0] imem [imem_depth];

	// program load port, used while the core is idle
	always_ff @(posedge clk) begin
		if (prog_we) begin
			imem[prog_addr[iaw-1:0]] <= prog_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (run && !hold) begin
			// a taken beqz in ID takes priority over the sequential step
			if (set_pc) begin
				pc <= set_pc_addr;
			end else if (!stall_id) begin
				pc <= pc + zhx_pkg::xlen'(1);
			end
		end
	end

	// nop until run goes high
	assign inst = run ? imem[pc[iaw-1:0]] : {zhx_pkg::op_nop, 11'b0};

endmodule

`default_nettype wire

//--- design/zhx_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module zhx_regfile (
	input wire clk,
	input wire rst_n,
	input wire [zhx_pkg::reg_addr_w-1:0] read_addr1,
	input wire [zhx_pkg::reg_addr_w-1:0] read_addr2,
	output logic [zhx_pkg::xlen-1:0] read_value1,
	output logic [zhx_pkg::xlen-1:0] read_value2,
	input wire we,
	input wire [zhx_pkg::reg_addr_w-1:0] write_addr,
	input wire [zhx_pkg::xlen-1:0] write_value,
	input wire [zhx_pkg::reg_addr_w-1:0] dbg_addr,
	output logic [zhx_pkg::xlen-1:0] dbg_value
);

	logic [zhx_pkg::xlen-1:0] regs [zhx_pkg::reg_count];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < zhx_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[write_addr] <= write_value;
		end
	end

	// writeback value wins over the stored one, so ID sees it this cycle
	assign read_value1 = (we && write_addr == read_addr1) ? write_value : regs[read_addr1];
	assign read_value2 = (we && write_addr == read_addr2) ? write_value : regs[read_addr2];
	assign dbg_value = (we && write_addr == dbg_addr) ? write_value : regs[dbg_addr];

endmodule

`default_nettype wire

//--- design/zhx_pkg.sv
`default_nettype none

package zhx_pkg;

	// datapath and register file sizes
	localparam int xlen = 16;
	localparam int reg_count = 8;
	localparam int reg_addr_w = 3;

	// major opcodes, inst[15:11]
	localparam logic [4:0] op_nop = 5'b00001;
	localparam logic [4:0] op_li = 5'b01101;
	localparam logic [4:0] op_addiu = 5'b01001;
	localparam logic [4:0] op_beqz = 5'b00100;
	localparam logic [4:0] op_lw = 5'b10011;
	localparam logic [4:0] op_sw = 5'b11011;
	// addu and subu
	localparam logic [4:0] op_rr = 5'b11100;
	// and and or
	localparam logic [4:0] op_logic = 5'b11101;

	// op_rr selects on inst[1:0]
	localparam logic [1:0] fn_addu = 2'b01;
	localparam logic [1:0] fn_subu = 2'b11;
	// op_logic selects on inst[4:0]
	localparam logic [4:0] fn_and = 5'b01100;
	localparam logic [4:0] fn_or = 5'b01101;

	// alu operations
	localparam logic [2:0] alu_add = 3'd0;
	localparam logic [2:0] alu_sub = 3'd1;
	localparam logic [2:0] alu_and = 3'd2;
	localparam logic [2:0] alu_or = 3'd3;
	localparam logic [2:0] alu_pass_b = 3'd4;

endpackage

`default_nettype wire
